//--- list.f
common/fifo_pkg.sv
hw/counter/wrap_counter.sv
hw/fifo/fifo_ptrs.sv
hw/fifo/fifo_store.sv
hw/wb_fifo_regs.sv
hw/wb_fifo_top.sv
verification/wb_fifo_checker.sv
verification/wb_fifo_tb.sv

//--- verification/wb_fifo_tb.sv
// Wishbone FIFO testbench, bus master with reference queue model and verdict
`timescale 1ns/1ps

module wb_fifo_tb;

  import fifo_pkg::*;

  // --------------------------------------------------------------------
  // Run sizing
  // --------------------------------------------------------------------

  localparam int clk_period = 40;
  localparam int num_random = 400;
  // Upper bound on directed transfers
  localparam int num_directed = 48;
  // Three clocks per transfer, ten leaves room
  localparam int limit_cycles = (num_directed + num_random) * 10 + 200;

  logic    clk;
  logic    rst;
  wb_req_t bus_req;
  wb_rsp_t bus_rsp;

  // Reference queue and sticky flags
  logic [data_width-1:0] model_q [$];
  logic                  model_ovf;
  logic                  model_udf;

  int unsigned           errors;
  int unsigned           xfers_issued;
  int unsigned           acks_seen;
  logic [data_width-1:0] last_rdata;

  wb_fifo_top i_dut (
    .clk    (clk),
    .rst    (rst),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp)
  );

  bind wb_fifo_top wb_fifo_checker i_checker (
    .clk    (clk),
    .rst    (rst),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp),
    .count  (count),
    .full   (full),
    .empty  (empty)
  );

  always #(clk_period / 2) clk = ~clk;

  // --------------------------------------------------------------------
  // Model and compare
  // --------------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
      errors++;
    end
  endtask

  // Read data by the register map, from the queue before this access
  function automatic logic [data_width-1:0] expected_read(input logic [adr_width-1:0] adr);
    logic [data_width-1:0] result;
    fifo_status_t          st;
    result = '0;
    if (adr == adr_data && model_q.size() != 0) begin
      result = model_q[0];
    end else if (adr == adr_status) begin
      st = '0;
      st.count = cnt_width'(model_q.size());
      st.empty = model_q.size() == 0;
      st.full = model_q.size() == fifo_depth;
      st.overflow = model_ovf;
      st.underflow = model_udf;
      result = st;
    end
    return result;
  endfunction

  // Effect of one acked transfer
  task automatic update_model(input wb_req_t req);
    if (req.adr == adr_data && req.we) begin
      if (model_q.size() == fifo_depth) begin
        model_ovf = 1'b1;
      end else begin
        model_q.push_back(req.dat_w);
      end
    end else if (req.adr == adr_data) begin
      if (model_q.size() == 0) begin
        model_udf = 1'b1;
      end else begin
        void'(model_q.pop_front());
      end
    end else if (req.adr == adr_ctrl && req.we && req.dat_w[0]) begin
      model_q.delete();
      model_ovf = 1'b0;
      model_udf = 1'b0;
    end
  endtask

  // Request is still held during the ack cycle
  always @(posedge clk) begin
    if (!rst && bus_rsp.ack) begin
      acks_seen++;
      if (!bus_req.we) begin
        check_value("bus_rsp.dat_r", bus_rsp.dat_r, expected_read(bus_req.adr));
      end
      update_model(bus_req);
    end
  end

  // --------------------------------------------------------------------
  // Bus master
  // --------------------------------------------------------------------

  task automatic bus_xfer(input logic we, input logic [adr_width-1:0] adr,
                          input logic [data_width-1:0] dat);
    @(posedge clk);
    bus_req.cyc <= 1'b1;
    bus_req.stb <= 1'b1;
    bus_req.we <= we;
    bus_req.adr <= adr;
    bus_req.dat_w <= dat;
    xfers_issued++;
    // Ack comes one clock after the request is seen
    do begin
      @(posedge clk);
    end while (!bus_rsp.ack);
    last_rdata = bus_rsp.dat_r;
    bus_req.cyc <= 1'b0;
    bus_req.stb <= 1'b0;
  endtask

  // --------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------

  initial begin
    int                    pick;
    logic [data_width-1:0] pushed [fifo_depth];
    void'($urandom(13999));
    clk = 1'b0;
    rst = 1'b1;
    bus_req = '0;
    model_ovf = 1'b0;
    model_udf = 1'b0;
    errors = 0;
    xfers_issued = 0;
    acks_seen = 0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Empty, no flags
    bus_xfer(1'b0, adr_status, '0);
    check_value("status after reset", last_rdata, 32'h10);

    // Move both pointers to 5 so the full run wraps
    for (int i = 0; i < 5; i++) begin
      bus_xfer(1'b1, adr_data, $urandom);
      bus_xfer(1'b0, adr_data, '0);
    end

    // Fill up, then one push too many
    for (int i = 0; i < fifo_depth; i++) begin
      pushed[i] = $urandom;
      bus_xfer(1'b1, adr_data, pushed[i]);
    end
    bus_xfer(1'b0, adr_status, '0);
    check_value("status when full", last_rdata, 32'h2c);
    bus_xfer(1'b1, adr_data, $urandom);
    bus_xfer(1'b0, adr_status, '0);
    check_value("status after overflow", last_rdata, 32'h6c);

    // Drain in push order across 11 to 0
    for (int i = 0; i < fifo_depth; i++) begin
      bus_xfer(1'b0, adr_data, '0);
      check_value("popped word", last_rdata, pushed[i]);
    end

    // Pop when empty, then flush clears all
    bus_xfer(1'b0, adr_data, '0);
    check_value("pop when empty", last_rdata, 32'h0);
    bus_xfer(1'b0, adr_status, '0);
    check_value("status after underflow", last_rdata, 32'hd0);
    bus_xfer(1'b1, adr_ctrl, 32'h1);
    bus_xfer(1'b0, adr_status, '0);
    check_value("status after flush", last_rdata, 32'h10);

    // Random mix, pushes lead so the fill crosses the wrap often
    for (int i = 0; i < num_random; i++) begin
      pick = $urandom_range(99, 0);
      if (pick < 45) begin
        bus_xfer(1'b1, adr_data, $urandom);
      end else if (pick < 83) begin
        bus_xfer(1'b0, adr_data, '0);
      end else if (pick < 95) begin
        bus_xfer(1'b0, adr_status, '0);
      end else if (pick < 97) begin
        bus_xfer(1'b0, adr_ctrl, '0);
      end else begin
        // Bit 0 random, so only some of these flush
        bus_xfer(1'b1, adr_ctrl, $urandom);
      end
    end

    repeat (3) @(posedge clk);
    check_value("ack count", acks_seen, xfers_issued);
    errors += i_dut.i_checker.assert_fails;
    $display("Run complete, %0d transfers, %0d errors", xfers_issued, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Ends a run that stopped making progress
  initial begin
    #(limit_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, a transfer never completed", limit_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- verification/wb_fifo_checker.sv
// Wishbone FIFO checker, bus protocol and occupancy invariants as assertions
`timescale 1ns/1ps

module wb_fifo_checker (
  input logic                           clk,
  input logic                           rst,
  input fifo_pkg::wb_req_t              bus_req,
  input fifo_pkg::wb_rsp_t              bus_rsp,
  input logic [fifo_pkg::cnt_width-1:0] count,
  input logic                           full,
  input logic                           empty
);

  import fifo_pkg::*;

  // Number of assertion failures so far
  int unsigned assert_fails = 0;

  // --------------------------------------------------------------------
  // Bus protocol
  // --------------------------------------------------------------------

  // Ack is a single-cycle pulse
  a_ack_single: assert property (@(posedge clk) disable iff (rst)
    bus_rsp.ack |=> !bus_rsp.ack)
    else begin
      assert_fails++;
      $error("ack stayed high for two cycles");
    end

  // No ack without a request seen on the edge before
  a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
    bus_rsp.ack |-> $past(bus_req.cyc && bus_req.stb))
    else begin
      assert_fails++;
      $error("ack raised without cyc and stb on the previous edge");
    end

  // --------------------------------------------------------------------
  // FIFO invariants
  // --------------------------------------------------------------------

  // Occupancy in range, flags never contradict
  a_count_range: assert property (@(posedge clk) disable iff (rst)
    (count <= cnt_width'(fifo_depth)) && !(full && empty))
    else begin
      assert_fails++;
      $error("occupancy above depth or full and empty both high");
    end

endmodule

//--- hw/wb_fifo_top.sv
// Wishbone FIFO top, joins the bus slave, FIFO control and storage
`timescale 1ns/1ps

module wb_fifo_top (
  input  logic              clk,
  input  logic              rst,
  input  fifo_pkg::wb_req_t bus_req,
  output fifo_pkg::wb_rsp_t bus_rsp
);

  import fifo_pkg::*;

  // ----------------------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------------------

  logic                  push;
  logic                  pop;
  logic                  flush;
  logic [ptr_width-1:0]  wr_ptr;
  logic [ptr_width-1:0]  rd_ptr;
  logic [cnt_width-1:0]  count;
  logic                  full;
  logic                  empty;
  logic [data_width-1:0] wr_data;
  logic [data_width-1:0] rd_data;

  // Bus slave and sticky flags
  wb_fifo_regs i_regs (
    .clk    (clk),
    .rst    (rst),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp),
    .push   (push),
    .pop    (pop),
    .flush  (flush),
    .rd_data(rd_data),
    .count  (count),
    .full   (full),
    .empty  (empty),
    .wr_data(wr_data)
  );

  // Pointers and occupancy
  fifo_ptrs i_ptrs (
    .clk   (clk),
    .rst   (rst),
    .push  (push),
    .pop   (pop),
    .flush (flush),
    .wr_ptr(wr_ptr),
    .rd_ptr(rd_ptr),
    .count (count),
    .full  (full),
    .empty (empty)
  );

  // Entry array
  fifo_store i_store (
    .clk    (clk),
    .push   (push),
    .wr_ptr (wr_ptr),
    .rd_ptr (rd_ptr),
    .wr_data(wr_data),
    .rd_data(rd_data)
  );

endmodule

//--- hw/wb_fifo_regs.sv
// Wishbone FIFO registers, decodes the bus, acks, builds status and sticky errors
`timescale 1ns/1ps

module wb_fifo_regs (
  input  logic                            clk,
  input  logic                            rst,
  input  fifo_pkg::wb_req_t               bus_req,
  output fifo_pkg::wb_rsp_t               bus_rsp,
  // Strobes to FIFO control, high in the ack cycle only
  output logic                            push,
  output logic                            pop,
  output logic                            flush,
  // Head entry from storage
  input  logic [fifo_pkg::data_width-1:0] rd_data,
  input  logic [fifo_pkg::cnt_width-1:0]  count,
  input  logic                            full,
  input  logic                            empty,
  output logic [fifo_pkg::data_width-1:0] wr_data
);

  import fifo_pkg::*;

  logic                  ack;
  logic [data_width-1:0] dat_r;
  logic                  req_valid;
  logic                  ack_cycle;
  logic                  is_data;
  logic                  is_status;
  logic                  is_ctrl;
  logic                  overflow;
  logic                  underflow;
  fifo_status_t          status;

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------

  assign req_valid = bus_req.cyc && bus_req.stb;
  // Master still holds the request while ack is up
  assign ack_cycle = ack && req_valid;

  assign is_data = bus_req.adr == adr_data;
  assign is_status = bus_req.adr == adr_status;
  assign is_ctrl = bus_req.adr == adr_ctrl;

  // Write data goes straight to storage
  assign wr_data = bus_req.dat_w;

  // Push dropped when full, pop dropped when empty
  assign push = ack_cycle && bus_req.we && is_data && !full;
  assign pop = ack_cycle && !bus_req.we && is_data && !empty;
  assign flush = ack_cycle && bus_req.we && is_ctrl && bus_req.dat_w[0];

  // ----------------------------------------------------------------------
  // Status word
  // ----------------------------------------------------------------------

  always_comb begin
    status = '0;
    status.count = count;
    status.empty = empty;
    status.full = full;
    status.overflow = overflow;
    status.underflow = underflow;
  end

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------

  // One-cycle ack on the first edge that sees the request
  // Read data is captured on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      ack <= 1'b0;
      dat_r <= '0;
    end else begin
      ack <= req_valid && !ack;
      dat_r <= '0;
      if (req_valid && !ack && !bus_req.we) begin
        if (is_data && !empty) begin
          dat_r <= rd_data;
        end else if (is_status) begin
          dat_r <= status;
        end
      end
    end
  end

  assign bus_rsp.ack = ack;
  assign bus_rsp.dat_r = dat_r;

  // ----------------------------------------------------------------------
  // Sticky error flags
  // ----------------------------------------------------------------------

  // Set by a dropped access, cleared only by flush or reset
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      overflow <= 1'b0;
      underflow <= 1'b0;
    end else if (ack_cycle && is_data) begin
      if (bus_req.we && full) begin
        overflow <= 1'b1;
      end
      if (!bus_req.we && empty) begin
        underflow <= 1'b1;
      end
    end
  end

endmodule

//--- hw/fifo/fifo_store.sv
// FIFO storage, twelve word register array with one write and one read port
`timescale 1ns/1ps

module fifo_store (
  input  logic                            clk,
  // Write enable, already gated by full
  input  logic                            push,
  input  logic [fifo_pkg::ptr_width-1:0]  wr_ptr,
  input  logic [fifo_pkg::ptr_width-1:0]  rd_ptr,
  input  logic [fifo_pkg::data_width-1:0] wr_data,
  output logic [fifo_pkg::data_width-1:0] rd_data
);

  import fifo_pkg::*;

  // ----------------------------------------------------------------------
  // Entries
  // ----------------------------------------------------------------------

  // One word per slot, contents undefined until written
  logic [data_width-1:0] mem [fifo_depth];

  // ----------------------------------------------------------------------
  // Write port
  // ----------------------------------------------------------------------

  // Lands on the edge that ends the push cycle
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // ----------------------------------------------------------------------
  // Read port
  // ----------------------------------------------------------------------

  // Head of queue, combinational
  // Pointers never pass ptr_max so the index stays in range
  assign rd_data = mem[rd_ptr];

endmodule

//--- hw/fifo/fifo_ptrs.sv
// FIFO control, keeps write and read pointers and occupancy, flags full and empty
`timescale 1ns/1ps

module fifo_ptrs (
  input  logic                           clk,
  input  logic                           rst,
  // One-cycle strobes from the bus slave
  input  logic                           push,
  input  logic                           pop,
  input  logic                           flush,
  output logic [fifo_pkg::ptr_width-1:0] wr_ptr,
  output logic [fifo_pkg::ptr_width-1:0] rd_ptr,
  output logic [fifo_pkg::cnt_width-1:0] count,
  output logic                           full,
  output logic                           empty
);

  import fifo_pkg::*;

  // ----------------------------------------------------------------------
  // Pointers
  // ----------------------------------------------------------------------

  // Write pointer, one step per push, wraps 11 to 0
  wrap_counter #(
    .max_value  (ptr_max),
    .max_change (1),
    .enable_wrap(1'b1)
  ) i_wr_ptr (
    .clk       (clk),
    .rst       (rst),
    .reinit    (flush),
    .incr_valid(push),
    .incr      (1'b1),
    .decr_valid(1'b0),
    .decr      (1'b0),
    .value     (wr_ptr),
    .value_next()
  );

  // Read pointer, one step per pop
  wrap_counter #(
    .max_value  (ptr_max),
    .max_change (1),
    .enable_wrap(1'b1)
  ) i_rd_ptr (
    .clk       (clk),
    .rst       (rst),
    .reinit    (flush),
    .incr_valid(pop),
    .incr      (1'b1),
    .decr_valid(1'b0),
    .decr      (1'b0),
    .value     (rd_ptr),
    .value_next()
  );

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------

  // Push adds and pop takes away in the same cycle
  // so both together leave the count as it is
  // The slave gates push by full and pop by empty, so no wrap
  wrap_counter #(
    .max_value  (fifo_depth),
    .max_change (1),
    .enable_wrap(1'b0)
  ) i_count (
    .clk       (clk),
    .rst       (rst),
    .reinit    (flush),
    .incr_valid(push),
    .incr      (1'b1),
    .decr_valid(pop),
    .decr      (1'b1),
    .value     (count),
    .value_next()
  );

  // ----------------------------------------------------------------------
  // Flags
  // ----------------------------------------------------------------------

  // Straight from the registered count
  assign full = count == cnt_width'(fifo_depth);
  assign empty = count == '0;

endmodule

//--- hw/counter/wrap_counter.sv
// Wrap counter, up/down by a variable step with reinit and modulo wrap
`timescale 1ns/1ps

module wrap_counter #(
  // Largest value held, inclusive
  parameter int max_value = 1,
  // Largest step per cycle, inclusive
  parameter int max_change = 1,
  // Wrap around zero and max_value instead of saturating arithmetic
  parameter bit enable_wrap = 1,
  localparam int value_width = $clog2(max_value + 1),
  localparam int change_width = $clog2(max_change + 1)
) (
  input  logic                    clk,
  input  logic                    rst,
  // Restart at zero, a same-cycle change applies on top of it
  input  logic                    reinit,
  input  logic                    incr_valid,
  input  logic [change_width-1:0] incr,
  input  logic                    decr_valid,
  input  logic [change_width-1:0] decr,
  output logic [ value_width-1:0] value,
  output logic [ value_width-1:0] value_next
);

  // ----------------------------------------------------------------------
  // Derived constants
  // ----------------------------------------------------------------------

  localparam int max_value_p1 = max_value + 1;
  // Power-of-two moduli wrap for free in the bit width
  localparam bit is_pow2 = (max_value_p1 & (max_value_p1 - 1)) == 0;
  // Room for value plus one full step before correction
  localparam int temp_width = $clog2(max_value + max_change + 1);

  logic                    value_loaden;
  logic [ value_width-1:0] base_value;
  logic [change_width-1:0] incr_qual;
  logic [change_width-1:0] decr_qual;
  logic [  temp_width-1:0] value_temp_incr;
  logic [  temp_width-1:0] value_temp;

  // ----------------------------------------------------------------------
  // Raw sum
  // ----------------------------------------------------------------------

  // Reinit restarts from zero
  assign base_value = reinit ? '0 : value;

  // Drop steps that are not valid
  assign incr_qual = incr_valid ? incr : '0;
  assign decr_qual = decr_valid ? decr : '0;

  assign value_temp_incr = temp_width'(base_value) + temp_width'(incr_qual);
  // Underflow shows up as a large unsigned value
  assign value_temp = value_temp_incr - temp_width'(decr_qual);

  // Hold unless something asks for a change
  assign value_loaden = reinit || incr_valid || decr_valid;

  // ----------------------------------------------------------------------
  // Wrap correction
  // ----------------------------------------------------------------------

  if (is_pow2 || !enable_wrap) begin : gen_no_wrap
    // Truncation is the wrap, or no wrap can happen
    assign value_next = value_temp[value_width-1:0];
  end else begin : gen_wrap
    logic [temp_width-1:0] modulus;
    logic [temp_width-1:0] value_temp_wrapped;
    logic                  is_net_decr;
    logic                  will_wrap;
    logic                  will_underflow;
    logic                  will_overflow;

    assign modulus = temp_width'(max_value_p1);

    // Out of range either way means one modulus off
    assign is_net_decr = decr_qual > incr_qual;
    assign will_wrap = value_temp > temp_width'(max_value);
    assign will_underflow = will_wrap && is_net_decr;
    assign will_overflow = will_wrap && !is_net_decr;

    // Add back on underflow, take away on overflow
    always_comb begin
      if (will_underflow) begin
        value_temp_wrapped = value_temp + modulus;
      end else if (will_overflow) begin
        value_temp_wrapped = value_temp - modulus;
      end else begin
        value_temp_wrapped = value_temp;
      end
    end

    assign value_next = value_temp_wrapped[value_width-1:0];
  end

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------

  // Loads only on reinit or a valid change
  always_ff @(posedge clk) begin
    if (rst) begin
      value <= '0;
    end else if (value_loaden) begin
      value <= value_next;
    end
  end

endmodule

//--- common/fifo_pkg.sv
// FIFO package with sizes, register map, Wishbone bus structs and status layout
package fifo_pkg;

  // ----------------------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------------------

  // Bus and FIFO word width
  localparam int data_width = 32;
  // Entry count, deliberately not a power of two
  localparam int fifo_depth = 12;
  // Pointers wrap after this value
  localparam int ptr_max = fifo_depth - 1;
  localparam int ptr_width = 4;
  // Occupancy runs 0 to fifo_depth
  localparam int cnt_width = 4;
  // Word address bits on the bus
  localparam int adr_width = 2;

  // ----------------------------------------------------------------------
  // Register map
  // ----------------------------------------------------------------------

  // Write pushes, read pops
  localparam logic [adr_width-1:0] adr_data = 2'd0;
  // Read-only status word
  localparam logic [adr_width-1:0] adr_status = 2'd1;
  // Bit 0 written as one flushes the FIFO
  localparam logic [adr_width-1:0] adr_ctrl = 2'd2;

  // ----------------------------------------------------------------------
  // Bus and status types
  // ----------------------------------------------------------------------

  // Master request, held until ack
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [adr_width-1:0]  adr;
    logic [data_width-1:0] dat_w;
  } wb_req_t;

  // Slave response
  typedef struct packed {
    logic                  ack;
    logic [data_width-1:0] dat_r;
  } wb_rsp_t;

  // Status word, count in the low nibble
  typedef struct packed {
    logic [data_width-9:0] zero;
    logic                  underflow;
    logic                  overflow;
    logic                  full;
    logic                  empty;
    logic [cnt_width-1:0]  count;
  } fifo_status_t;

endpackage
